/* logic/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_BITS 5

// byte address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* logic/rv_core_pkg.sv */
`default_nettype none
`include "rv_core_defines.svh"

package rv_core_pkg;

  //////////////////////////////
  // instruction formats
  //////////////////////////////

  typedef struct packed {
    logic [6:0]              funct7;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [2:0]              funct3;
    logic [`RV_REG_BITS-1:0] rd;
    logic [6:0]              opcode;
  } rv_fmt_r_t;

  typedef struct packed {
    logic [11:0]             imm;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [2:0]              funct3;
    logic [`RV_REG_BITS-1:0] rd;
    logic [6:0]              opcode;
  } rv_fmt_i_t;

  typedef struct packed {
    logic [6:0]              imm_hi;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [2:0]              funct3;
    logic [4:0]              imm_lo;
    logic [6:0]              opcode;
  } rv_fmt_s_t;

  typedef struct packed {
    logic                    imm12;
    logic [5:0]              imm10_5;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [2:0]              funct3;
    logic [3:0]              imm4_1;
    logic                    imm11;
    logic [6:0]              opcode;
  } rv_fmt_b_t;

  typedef struct packed {
    logic [19:0]             imm;
    logic [`RV_REG_BITS-1:0] rd;
    logic [6:0]              opcode;
  } rv_fmt_u_t;

  typedef struct packed {
    logic                    imm20;
    logic [9:0]              imm10_1;
    logic                    imm11;
    logic [7:0]              imm19_12;
    logic [`RV_REG_BITS-1:0] rd;
    logic [6:0]              opcode;
  } rv_fmt_j_t;

  // one instruction word, read through whichever format applies
  typedef union packed {
    rv_fmt_r_t r;
    rv_fmt_i_t i;
    rv_fmt_s_t s;
    rv_fmt_b_t b;
    rv_fmt_u_t u;
    rv_fmt_j_t j;
  } rv_instr_u;

  //////////////////////////////
  // pipeline types
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS2
  } rv_alu_op_e;

  typedef struct packed {
    logic                    valid;
    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_REG_BITS-1:0] rs1;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rd;
    rv_alu_op_e              alu_op;
    logic                    use_imm;
    logic [`RV_XLEN-1:0]     imm;
    logic                    load;
    logic                    store;
    logic [1:0]              size;
    logic                    unsign;
    logic                    branch;
    logic [2:0]              cond;
    logic                    jal;
  } rv_dec_op_t;

  typedef struct packed {
    logic [`RV_XLEN-3:0] adr;
    logic [`RV_XLEN-1:0] dat;
    logic [3:0]          sel;
    logic                we;
  } rv_wb_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] dat;
    logic                ack;
  } rv_wb_rsp_t;

endpackage

`default_nettype wire

/* logic/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_fetch (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   redirect_valid_i,
  input  wire logic [`RV_XLEN-1:0]    redirect_pc_i,
  input  wire logic                   dec_ready_i,
  input  wire rv_core_pkg::rv_wb_rsp_t bus_rsp_i,
  output logic                        bus_req_valid_o,
  output rv_core_pkg::rv_wb_req_t     bus_req_o,
  output logic                        instr_valid_o,
  output rv_core_pkg::rv_instr_u      instr_o,
  output logic [`RV_XLEN-1:0]         instr_pc_o
);

  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] req_pc_q;
  logic [`RV_XLEN-1:0] issue_pc;
  logic [`RV_XLEN-1:0] ipc_q;
  rv_instr_u           instr_q;
  logic                req_q;
  logic                stale_q;
  logic                valid_q;
  logic                ack;
  logic                fill;
  logic                next_valid;
  logic                issue;

  assign ack = bus_rsp_i.ack;

  // a stale word or one arriving with a redirect is dropped
  assign fill = ack & ~stale_q & ~redirect_valid_i;
  assign next_valid = ~redirect_valid_i & (fill | (valid_q & ~dec_ready_i));

  // one fetch outstanding, and only into an empty output register
  assign issue = (~req_q | ack) & ~next_valid;
  assign issue_pc = redirect_valid_i ? redirect_pc_i : pc_q;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= `RV_RESET_PC;
      req_q <= 1'b0;
      stale_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= next_valid;
      // an unacked fetch turns stale on redirect
      stale_q <= req_q & ~ack & (stale_q | redirect_valid_i);
      if (issue) begin
        req_q <= 1'b1;
        pc_q <= issue_pc + `RV_XLEN'd4;
      end else begin
        if (ack) begin
          req_q <= 1'b0;
        end
        if (redirect_valid_i) begin
          pc_q <= redirect_pc_i;
        end
      end
    end
  end

  // request address and fetched word
  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_pc_q <= issue_pc;
    end
    if (fill) begin
      instr_q <= bus_rsp_i.dat;
      ipc_q <= req_pc_q;
    end
  end

  always_comb begin
    bus_req_o.adr = req_pc_q[`RV_XLEN-1:2];
    bus_req_o.dat = '0;
    bus_req_o.sel = 4'b1111;
    bus_req_o.we = 1'b0;
  end

  assign bus_req_valid_o = req_q;
  assign instr_valid_o = valid_q;
  assign instr_o = instr_q;
  assign instr_pc_o = ipc_q;

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_decode (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   instr_valid_i,
  input  wire rv_core_pkg::rv_instr_u instr_i,
  input  wire logic [`RV_XLEN-1:0]    instr_pc_i,
  input  wire logic                   ex_ready_i,
  input  wire logic                   flush_i,
  output logic                        instr_ready_o,
  output logic [`RV_REG_BITS-1:0]     rs1_addr_o,
  output logic [`RV_REG_BITS-1:0]     rs2_addr_o,
  output rv_core_pkg::rv_dec_op_t     op_o
);

  import rv_core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                alt;
  rv_alu_op_e          alu_sel;
  rv_dec_op_t          dec;
  rv_dec_op_t          op_q;

  //////////////////////////////
  // immediates
  //////////////////////////////

  assign imm_i = {{(`RV_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s = {{(`RV_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_b = {{(`RV_XLEN-12){instr_i.b.imm12}}, instr_i.b.imm11,
                  instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_u = {instr_i.u.imm, 12'b0};
  assign imm_j = {{(`RV_XLEN-20){instr_i.j.imm20}}, instr_i.j.imm19_12,
                  instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

  // sub and sra share funct7 bit 5, srai only among the immediates
  assign alt = instr_i.r.funct7[5] &
               ((instr_i.r.opcode == OPC_OP) | (instr_i.r.funct3 == 3'b101));

  always_comb begin
    case (instr_i.r.funct3)
      3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  end

  //////////////////////////////
  // operation decode
  //////////////////////////////

  always_comb begin
    dec = '0;
    dec.valid = instr_valid_i;
    dec.pc = instr_pc_i;
    dec.rs1 = instr_i.r.rs1;
    dec.rs2 = instr_i.r.rs2;
    dec.alu_op = ALU_ADD;
    dec.size = instr_i.r.funct3[1:0];
    dec.unsign = instr_i.r.funct3[2];
    dec.cond = instr_i.r.funct3;
    // rd stays zero for anything that writes no register
    case (instr_i.r.opcode)
      OPC_OP: begin
        dec.rd = instr_i.r.rd;
        dec.alu_op = alu_sel;
      end
      OPC_OP_IMM: begin
        dec.rd = instr_i.r.rd;
        dec.alu_op = alu_sel;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
      end
      OPC_LUI: begin
        dec.rd = instr_i.r.rd;
        dec.alu_op = ALU_PASS2;
        dec.use_imm = 1'b1;
        dec.imm = imm_u;
      end
      OPC_LOAD: begin
        dec.rd = instr_i.r.rd;
        dec.load = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
      end
      OPC_STORE: begin
        dec.store = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm = imm_s;
      end
      OPC_BRANCH: begin
        dec.branch = 1'b1;
        dec.imm = imm_b;
      end
      OPC_JAL: begin
        dec.rd = instr_i.r.rd;
        dec.jal = 1'b1;
        dec.imm = imm_j;
      end
      default: begin
        dec.rd = '0;
      end
    endcase
  end

  assign instr_ready_o = ~op_q.valid | ex_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      op_q.valid <= 1'b0;
    end else if (instr_ready_o) begin
      op_q <= dec;
    end
  end

  // register file is read by the operation now in execute
  assign rs1_addr_o = op_q.rs1;
  assign rs2_addr_o = op_q.rs2;
  assign op_o = op_q;

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_regfile (
  input  wire logic                   clk_i,
  input  wire logic [`RV_REG_BITS-1:0] rs1_addr_i,
  input  wire logic [`RV_REG_BITS-1:0] rs2_addr_i,
  input  wire logic                   wr_en_i,
  input  wire logic [`RV_REG_BITS-1:0] wr_addr_i,
  input  wire logic [`RV_XLEN-1:0]    wr_data_i,
  output logic [`RV_XLEN-1:0]         rs1_data_o,
  output logic [`RV_XLEN-1:0]         rs2_data_o
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:(2**`RV_REG_BITS)-1];

  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_BITS-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    // same-cycle write bypass
    if (wr_en_i && (wr_addr_i == addr)) begin
      return wr_data_i;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk_i) begin
    if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_execute (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire rv_core_pkg::rv_dec_op_t op_i,
  input  wire logic [`RV_XLEN-1:0]     rs1_data_i,
  input  wire logic [`RV_XLEN-1:0]     rs2_data_i,
  input  wire rv_core_pkg::rv_wb_rsp_t bus_rsp_i,
  output logic                         op_ready_o,
  output logic                         bus_req_valid_o,
  output rv_core_pkg::rv_wb_req_t      bus_req_o,
  output logic                         redirect_valid_o,
  output logic [`RV_XLEN-1:0]          redirect_pc_o,
  output logic                         wr_en_o,
  output logic [`RV_REG_BITS-1:0]      wr_addr_o,
  output logic [`RV_XLEN-1:0]          wr_data_o
);

  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0]     rs1_val;
  logic [`RV_XLEN-1:0]     rs2_val;
  logic [`RV_XLEN-1:0]     op_b;
  logic [`RV_XLEN-1:0]     alu_res;
  logic [`RV_XLEN-1:0]     ld_word;
  logic [`RV_XLEN-1:0]     ld_val;
  logic [`RV_XLEN-1:0]     result;
  logic [1:0]              mem_off;
  logic [3:0]              sel;
  logic                    taken;
  logic                    mem_op;
  logic                    retire;
  logic                    wb_write;
  logic                    wr_en_q;
  logic [`RV_REG_BITS-1:0] wb_rd_q;
  logic [`RV_XLEN-1:0]     wb_data_q;

  // forward from the writeback register
  assign rs1_val = ((wb_rd_q == op_i.rs1) && (wb_rd_q != '0)) ? wb_data_q : rs1_data_i;
  assign rs2_val = ((wb_rd_q == op_i.rs2) && (wb_rd_q != '0)) ? wb_data_q : rs2_data_i;
  assign op_b = op_i.use_imm ? op_i.imm : rs2_val;

  //////////////////////////////
  // ALU and branch compare
  //////////////////////////////

  always_comb begin
    case (op_i.alu_op)
      ALU_SUB:   alu_res = rs1_val - op_b;
      ALU_SLL:   alu_res = rs1_val << op_b[4:0];
      ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      ALU_SLTU:  alu_res = {{(`RV_XLEN-1){1'b0}}, rs1_val < op_b};
      ALU_XOR:   alu_res = rs1_val ^ op_b;
      ALU_SRL:   alu_res = rs1_val >> op_b[4:0];
      ALU_SRA:   alu_res = $signed(rs1_val) >>> op_b[4:0];
      ALU_OR:    alu_res = rs1_val | op_b;
      ALU_AND:   alu_res = rs1_val & op_b;
      ALU_PASS2: alu_res = op_b;
      default:   alu_res = rs1_val + op_b;
    endcase
  end

  always_comb begin
    case (op_i.cond)
      3'b000:  taken = rs1_val == rs2_val;
      3'b001:  taken = rs1_val != rs2_val;
      3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  taken = rs1_val < rs2_val;
      3'b111:  taken = rs1_val >= rs2_val;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_valid_o = op_i.valid & (op_i.jal | (op_i.branch & taken));
  assign redirect_pc_o = op_i.pc + op_i.imm;

  //////////////////////////////
  // load / store
  //////////////////////////////

  // address is the ALU sum of rs1 and the immediate
  assign mem_off = alu_res[1:0];
  assign mem_op = op_i.valid & (op_i.load | op_i.store);

  always_comb begin
    case (op_i.size)
      2'b00:   sel = 4'b0001 << mem_off;
      2'b01:   sel = 4'b0011 << {mem_off[1], 1'b0};
      default: sel = 4'b1111;
    endcase
  end

  always_comb begin
    bus_req_o.adr = alu_res[`RV_XLEN-1:2];
    bus_req_o.dat = rs2_val << {mem_off, 3'b000};
    bus_req_o.sel = sel;
    bus_req_o.we = op_i.store;
  end

  assign bus_req_valid_o = mem_op;

  // held until the access is acked
  assign op_ready_o = ~mem_op | bus_rsp_i.ack;

  assign ld_word = bus_rsp_i.dat >> {mem_off, 3'b000};

  always_comb begin
    case (op_i.size)
      2'b00:   ld_val = {{(`RV_XLEN-8){ld_word[7] & ~op_i.unsign}}, ld_word[7:0]};
      2'b01:   ld_val = {{(`RV_XLEN-16){ld_word[15] & ~op_i.unsign}}, ld_word[15:0]};
      default: ld_val = ld_word;
    endcase
  end

  //////////////////////////////
  // writeback register
  //////////////////////////////

  always_comb begin
    if (op_i.load) begin
      result = ld_val;
    end else if (op_i.jal) begin
      result = op_i.pc + `RV_XLEN'd4;
    end else begin
      result = alu_res;
    end
  end

  assign retire = op_i.valid & op_ready_o;
  assign wb_write = retire & (op_i.rd != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_en_q <= 1'b0;
      wb_rd_q <= '0;
    end else begin
      wr_en_q <= wb_write;
      if (wb_write) begin
        wb_rd_q <= op_i.rd;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_write) begin
      wb_data_q <= result;
    end
  end

  assign wr_en_o = wr_en_q;
  assign wr_addr_o = wb_rd_q;
  assign wr_data_o = wb_data_q;

endmodule

`default_nettype wire

/* logic/rv_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_bus_arbiter (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    fetch_req_valid_i,
  input  wire rv_core_pkg::rv_wb_req_t fetch_req_i,
  input  wire logic                    data_req_valid_i,
  input  wire rv_core_pkg::rv_wb_req_t data_req_i,
  input  wire logic [`RV_XLEN-1:0]     dat_i,
  input  wire logic                    ack_i,
  output rv_core_pkg::rv_wb_rsp_t      fetch_rsp_o,
  output rv_core_pkg::rv_wb_rsp_t      data_rsp_o,
  output logic                         cyc_o,
  output logic                         stb_o,
  output logic                         we_o,
  output logic [`RV_XLEN-3:0]          adr_o,
  output logic [3:0]                   sel_o,
  output logic [`RV_XLEN-1:0]          dat_o
);

  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    OWN_IDLE,
    OWN_FETCH,
    OWN_DATA
  } owner_e;

  owner_e     own_q;
  rv_wb_req_t req;

  // data wins when idle, grant held until ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      own_q <= OWN_IDLE;
    end else begin
      case (own_q)
        OWN_IDLE: begin
          if (data_req_valid_i) begin
            own_q <= OWN_DATA;
          end else if (fetch_req_valid_i) begin
            own_q <= OWN_FETCH;
          end
        end
        default: begin
          if (ack_i) begin
            own_q <= OWN_IDLE;
          end
        end
      endcase
    end
  end

  assign req = (own_q == OWN_DATA) ? data_req_i : fetch_req_i;

  assign cyc_o = own_q != OWN_IDLE;
  assign stb_o = cyc_o;
  assign we_o = cyc_o & req.we;
  assign adr_o = req.adr;
  assign sel_o = req.sel;
  assign dat_o = req.dat;

  // ack goes only to the owner
  always_comb begin
    fetch_rsp_o.dat = dat_i;
    fetch_rsp_o.ack = ack_i & (own_q == OWN_FETCH);
    data_rsp_o.dat = dat_i;
    data_rsp_o.ack = ack_i & (own_q == OWN_DATA);
  end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_core (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  // wishbone classic master
  output logic                     cyc_o,
  output logic                     stb_o,
  output logic                     we_o,
  output logic [`RV_XLEN-3:0]      adr_o,
  output logic [3:0]               sel_o,
  output logic [`RV_XLEN-1:0]      dat_o,
  input  wire logic [`RV_XLEN-1:0] dat_i,
  input  wire logic                ack_i
);

  import rv_core_pkg::*;

  logic                    fetch_req_valid;
  rv_wb_req_t              fetch_req;
  rv_wb_rsp_t              fetch_rsp;
  logic                    data_req_valid;
  rv_wb_req_t              data_req;
  rv_wb_rsp_t              data_rsp;
  logic                    instr_valid;
  rv_instr_u               instr;
  logic [`RV_XLEN-1:0]     instr_pc;
  logic                    instr_ready;
  rv_dec_op_t              dec_op;
  logic                    ex_ready;
  logic [`RV_REG_BITS-1:0] rs1_addr;
  logic [`RV_REG_BITS-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]     rs1_data;
  logic [`RV_XLEN-1:0]     rs2_data;
  logic                    redirect_valid;
  logic [`RV_XLEN-1:0]     redirect_pc;
  logic                    wr_en;
  logic [`RV_REG_BITS-1:0] wr_addr;
  logic [`RV_XLEN-1:0]     wr_data;

  //////////////////////////////
  // pipeline stages
  //////////////////////////////

  rv_fetch u_fetch (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .dec_ready_i      (instr_ready),
    .bus_rsp_i        (fetch_rsp),
    .bus_req_valid_o  (fetch_req_valid),
    .bus_req_o        (fetch_req),
    .instr_valid_o    (instr_valid),
    .instr_o          (instr),
    .instr_pc_o       (instr_pc)
  );

  rv_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_pc_i    (instr_pc),
    .ex_ready_i    (ex_ready),
    .flush_i       (redirect_valid),
    .instr_ready_o (instr_ready),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .op_o          (dec_op)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute u_execute (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .op_i             (dec_op),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .bus_rsp_i        (data_rsp),
    .op_ready_o       (ex_ready),
    .bus_req_valid_o  (data_req_valid),
    .bus_req_o        (data_req),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .wr_en_o          (wr_en),
    .wr_addr_o        (wr_addr),
    .wr_data_o        (wr_data)
  );

  //////////////////////////////
  // shared bus port
  //////////////////////////////

  rv_bus_arbiter u_bus_arbiter (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .fetch_req_valid_i (fetch_req_valid),
    .fetch_req_i       (fetch_req),
    .data_req_valid_i  (data_req_valid),
    .data_req_i        (data_req),
    .dat_i             (dat_i),
    .ack_i             (ack_i),
    .fetch_rsp_o       (fetch_rsp),
    .data_rsp_o        (data_rsp),
    .cyc_o             (cyc_o),
    .stb_o             (stb_o),
    .we_o              (we_o),
    .adr_o             (adr_o),
    .sel_o             (sel_o),
    .dat_o             (dat_o)
  );

endmodule

`default_nettype wire

/* bench/rv_wb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_wb_memory (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire logic        cyc_i,
  input  wire logic        stb_i,
  input  wire logic        we_i,
  input  wire logic [29:0] adr_i,
  input  wire logic [3:0]  sel_i,
  input  wire logic [31:0] dat_i,
  output logic [31:0]      dat_o,
  output logic             ack_o
);

  // 256 words, loaded by the testbench
  logic [31:0] mem [0:255];
  logic        busy_q;
  logic [1:0]  wait_q;

  initial begin
    ack_o = 1'b0;
    dat_o = '0;
    busy_q = 1'b0;
    wait_q = '0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_o <= 1'b0;
      busy_q <= 1'b0;
    end else if (ack_o) begin
      // master drops or changes the request after ack
      ack_o <= 1'b0;
      busy_q <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (!busy_q) begin
        busy_q <= 1'b1;
        wait_q <= $urandom % 4;
      end else if (wait_q == 2'd0) begin
        ack_o <= 1'b1;
        dat_o <= mem[adr_i[7:0]];
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem[adr_i[7:0]][8*b +: 8] <= dat_i[8*b +: 8];
            end
          end
        end
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_core_tb;

  localparam int N_TESTS = 7;
  localparam int CYCLES_PER_TEST = 500;
  localparam int WAIT_LIMIT = 400;

  logic        clk_i;
  logic        reset_i;
  logic        cyc_o;
  logic        stb_o;
  logic        we_o;
  logic [29:0] adr_o;
  logic [3:0]  sel_o;
  logic [31:0] dat_o;
  logic [31:0] dat_i;
  logic        ack_i;

  // test table
  string       test_name [N_TESTS];
  logic [31:0] prog [N_TESTS][16];
  int          prog_len [N_TESTS];
  logic [31:0] res_addr [N_TESTS];
  logic [31:0] exp_word [N_TESTS];
  int          n_def;
  int          n_pass;
  int          n_fail;

  always #4 clk_i = ~clk_i;

  rv_core dut0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cyc_o   (cyc_o),
    .stb_o   (stb_o),
    .we_o    (we_o),
    .adr_o   (adr_o),
    .sel_o   (sel_o),
    .dat_o   (dat_o),
    .dat_i   (dat_i),
    .ack_i   (ack_i)
  );

  rv_wb_memory mem0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cyc_i   (cyc_o),
    .stb_i   (stb_o),
    .we_i    (we_o),
    .adr_i   (adr_o),
    .sel_i   (sel_o),
    .dat_i   (dat_o),
    .dat_o   (dat_i),
    .ack_o   (ack_i)
  );

  //////////////////////////////
  // instruction encoders
  //////////////////////////////

  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] alu_ri(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] ld(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] st(input logic [2:0] f3, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] br(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic begin_test(input string nm, input logic [31:0] ra, input logic [31:0] ev);
    test_name[n_def] = nm;
    res_addr[n_def] = ra;
    exp_word[n_def] = ev;
    prog_len[n_def] = 0;
    n_def++;
  endtask

  task automatic emit(input logic [31:0] w);
    prog[n_def-1][prog_len[n_def-1]] = w;
    prog_len[n_def-1]++;
  endtask

  //////////////////////////////
  // programs
  //////////////////////////////

  task automatic build_table();
    // each alu result feeds the next instruction
    begin_test("alu_chain", 32'h300, 32'h0000_07d8);
    emit(alu_ri(3'd0, 1, 0, 5));
    emit(alu_ri(3'd0, 2, 1, -3));
    emit(alu_rr(7'h00, 3'd1, 3, 1, 2));
    emit(alu_ri(3'd1, 4, 3, 3));
    emit(alu_rr(7'h20, 3'd0, 5, 2, 4));
    emit(alu_ri(3'd5, 6, 5, 32'h402));
    emit(alu_ri(3'd5, 7, 5, 28));
    emit(alu_rr(7'h00, 3'd2, 8, 5, 1));
    emit(alu_rr(7'h00, 3'd3, 9, 5, 1));
    emit(alu_rr(7'h00, 3'd4, 10, 6, 7));
    emit(alu_rr(7'h00, 3'd0, 10, 10, 8));
    emit(alu_rr(7'h00, 3'd6, 10, 10, 9));
    emit(alu_ri(3'd7, 11, 10, 32'h7ff));
    emit(st(3'd2, 11, 0, 32'h300));
    emit(jal(0, 0));

    // word 0xf08c7f85 read back in pieces
    begin_test("load_ext", 32'h300, 32'hfffe_80fa);
    emit(lui(1, 20'hf08c8));
    emit(alu_ri(3'd0, 1, 1, -123));
    emit(st(3'd2, 1, 0, 32'h100));
    emit(ld(3'd0, 2, 0, 32'h100));
    emit(ld(3'd4, 3, 0, 32'h100));
    emit(ld(3'd0, 4, 0, 32'h101));
    emit(ld(3'd1, 5, 0, 32'h102));
    emit(ld(3'd5, 6, 0, 32'h102));
    emit(ld(3'd1, 7, 0, 32'h100));
    emit(alu_rr(7'h20, 3'd0, 8, 2, 3));
    emit(alu_rr(7'h20, 3'd0, 9, 5, 6));
    emit(alu_rr(7'h00, 3'd0, 8, 8, 9));
    emit(alu_rr(7'h00, 3'd0, 8, 8, 4));
    emit(alu_rr(7'h00, 3'd4, 8, 8, 7));
    emit(st(3'd2, 8, 0, 32'h300));
    emit(jal(0, 0));

    begin_test("store_bytes", 32'h300, 32'habab_cdef);
    emit(lui(1, 20'h12345));
    emit(alu_ri(3'd0, 1, 1, 32'h678));
    emit(st(3'd2, 1, 0, 32'h104));
    emit(alu_ri(3'd0, 2, 0, 32'h0ab));
    emit(st(3'd0, 2, 0, 32'h106));
    emit(lui(3, 20'hffffd));
    emit(alu_ri(3'd0, 3, 3, -32'h211));
    emit(st(3'd1, 3, 0, 32'h104));
    emit(st(3'd0, 2, 0, 32'h107));
    emit(ld(3'd2, 4, 0, 32'h104));
    emit(st(3'd2, 4, 0, 32'h300));
    emit(jal(0, 0));

    // x1 is -1 and x2 is 1
    // skipped adds would set high bits
    begin_test("branch_fwd", 32'h300, 32'h0000_0007);
    emit(alu_ri(3'd0, 1, 0, -1));
    emit(alu_ri(3'd0, 2, 0, 1));
    emit(br(3'd0, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 0, 1));
    emit(br(3'd1, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h100));
    emit(br(3'd4, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h200));
    emit(br(3'd5, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 10, 2));
    emit(br(3'd6, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 10, 4));
    emit(br(3'd7, 1, 2, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h400));
    emit(st(3'd2, 10, 0, 32'h300));
    emit(jal(0, 0));

    // same six conditions with opposite outcomes
    begin_test("branch_rev", 32'h300, 32'h0000_0007);
    emit(alu_ri(3'd0, 1, 0, -1));
    emit(alu_ri(3'd0, 2, 0, 1));
    emit(br(3'd1, 1, 1, 8));
    emit(alu_ri(3'd0, 10, 0, 1));
    emit(br(3'd0, 1, 1, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h100));
    emit(br(3'd4, 2, 1, 8));
    emit(alu_ri(3'd0, 10, 10, 2));
    emit(br(3'd5, 2, 1, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h200));
    emit(br(3'd6, 2, 1, 8));
    emit(alu_ri(3'd0, 10, 10, 32'h400));
    emit(br(3'd7, 2, 1, 8));
    emit(alu_ri(3'd0, 10, 10, 4));
    emit(st(3'd2, 10, 0, 32'h300));
    emit(jal(0, 0));

    // link of the jal at pc 4 is 8 and x1 adds 3
    begin_test("jal_link", 32'h300, 32'h0000_000b);
    emit(alu_ri(3'd0, 1, 0, 3));
    emit(jal(5, 12));
    emit(alu_ri(3'd0, 1, 1, 32'h100));
    emit(alu_ri(3'd0, 1, 1, 32'h200));
    emit(alu_rr(7'h00, 3'd0, 6, 5, 1));
    emit(jal(0, 8));
    emit(alu_ri(3'd0, 6, 6, 32'h400));
    emit(st(3'd2, 6, 0, 32'h300));
    emit(jal(0, 0));

    begin_test("x0_reads", 32'h300, 32'h0000_0007);
    emit(alu_ri(3'd0, 0, 0, 55));
    emit(alu_rr(7'h00, 3'd0, 1, 0, 0));
    emit(lui(0, 20'h12345));
    emit(alu_ri(3'd0, 2, 0, 7));
    emit(alu_rr(7'h00, 3'd0, 0, 2, 2));
    emit(alu_rr(7'h00, 3'd0, 3, 0, 2));
    emit(alu_rr(7'h00, 3'd0, 3, 3, 1));
    emit(st(3'd2, 3, 0, 32'h300));
    emit(jal(0, 0));
  endtask

  //////////////////////////////
  // one test run
  //////////////////////////////

  task automatic run_test(input int t);
    int          cycles;
    logic        ok;
    logic        seen;
    logic [31:0] got;
    logic [3:0]  got_sel;
    logic [31:0] reset_pc;
    ok = 1'b1;
    seen = 1'b0;
    cycles = 0;
    got = '0;
    got_sel = '0;
    reset_pc = `RV_RESET_PC;
    @(posedge clk_i);
    reset_i <= 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < 256; i++) begin
      mem0.mem[i] = 32'hc0de_0000 | i;
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      mem0.mem[i] = prog[t][i];
    end
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    if ({cyc_o, stb_o, we_o} !== 3'b000) begin
      $display("[ERROR] %s reset: expected cyc/stb/we 000, actual %b%b%b",
               test_name[t], cyc_o, stb_o, we_o);
      ok = 1'b0;
    end
    @(posedge clk_i);
    reset_i <= 1'b0;
    // first request must be the reset fetch
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      if (cyc_o && stb_o) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      $display("%s: the core made no bus request after reset", test_name[t]);
      ok = 1'b0;
    end else if (adr_o !== reset_pc[31:2]) begin
      $display("[ERROR] %s first fetch: expected adr %08h, actual %08h",
               test_name[t], reset_pc[31:2], adr_o);
      ok = 1'b0;
    end
    seen = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      if (cyc_o && stb_o && we_o && ack_i && adr_o == res_addr[t][31:2]) begin
        got = dat_o;
        got_sel = sel_o;
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      $display("%s: the result was never written within %0d cycles", test_name[t],
               WAIT_LIMIT);
      ok = 1'b0;
    end else if (got !== exp_word[t]) begin
      $display("[ERROR] %s: expected %08h, actual %08h", test_name[t], exp_word[t], got);
      ok = 1'b0;
    end
    // the result is a word store
    if (seen && got_sel !== 4'b1111) begin
      $display("[ERROR] %s result sel: expected 1111, actual %b", test_name[t], got_sel);
      ok = 1'b0;
    end
    if (ok) begin
      n_pass++;
      $display("pass %s: result %08h", test_name[t], got);
    end else begin
      n_fail++;
      $display("fail %s", test_name[t]);
    end
  endtask

  // watchdog
  initial begin
    #(N_TESTS * CYCLES_PER_TEST * 8);
    $display("run timed out after %0d test lengths", N_TESTS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    n_def = 0;
    n_pass = 0;
    n_fail = 0;
    void'($urandom(32'h3ade));
    build_table();
    for (int t = 0; t < n_def; t++) begin
      run_test(t);
    end
    $display("%0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && n_pass == N_TESTS) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_bus_arbiter.sv
logic/rv_core.sv
bench/rv_wb_memory.sv
bench/rv_core_tb.sv
